//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_noc_axi_slave
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "sim passed"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+hdl
hdl/noc_axi_pkg.sv
hdl/sync_fifo.sv
hdl/axi_ot_if.sv
hdl/axi_req_decode.sv
hdl/axi_wr_execute.sv
hdl/axi_rd_execute.sv
hdl/noc_rx_buffers.sv
hdl/noc_axi_slave.sv
sim/noc_axi_slave_props.sv
sim/tb_noc_axi_slave.sv

//--- hdl/axi_ot_if.sv
// Head of an outstanding-request queue
interface axi_ot_if
  import noc_axi_pkg::*;
();

  // Queue holds at least one request
  logic      valid;
  // Oldest request, region forced to NONE on error
  ot_entry_t entry;
  // One-cycle pulse, drops the head entry
  logic      pop;

  // Queue side
  modport decode (
    output valid,
    output entry,
    input  pop
  );

  // Consumer side
  modport exec (
    input  valid,
    input  entry,
    output pop
  );

endinterface

//--- hdl/axi_rd_execute.sv
`include "noc_axi_params.svh"

module axi_rd_execute
  import noc_axi_pkg::*;
(
  input  logic                   clk_axi,
  input  logic                   arst_axi,
  input  logic                   rready_i,
  input  logic [`NOC_NUM_VC-1:0] empty_i,
  input  logic [`NOC_DATA_W-1:0] buf_data_i,
  output logic                   rvalid_o,
  output logic [`NOC_DATA_W-1:0] rdata_o,
  output axi_resp_e              rresp_o,
  output logic [`NOC_ID_W-1:0]   rid_o,
  output logic                   rlast_o,
  output logic [`NOC_VC_W-1:0]   rd_vc_o,
  output logic                   rd_pop_o,
  axi_ot_if.exec                 ot_i
);

  ot_entry_t             head;
  logic                  err;
  logic                  r_hs;
  logic                  active_q;
  logic [`NOC_LEN_W-1:0] beat_q;

  assign head = ot_i.entry;

  // Anything outside the read window answers with a single error beat
  assign err = (head.region != REGION_RD_FIFO);

  // Buffer select follows the head request
  assign rd_vc_o = head.vc;

  // ************************************************************
  // R channel
  // ************************************************************
  // Data beats wait on the channel buffer, so latency varies
  assign rvalid_o = active_q && (err || !empty_i[head.vc]);
  assign rdata_o  = err ? '0 : buf_data_i;
  assign rresp_o  = err ? RESP_SLVERR : RESP_OKAY;
  assign rid_o    = head.id;
  assign rlast_o  = rvalid_o && (err || (beat_q == head.len));

  assign r_hs = rvalid_o && rready_i;

  // Consume one flit per accepted data beat
  assign rd_pop_o = r_hs && !err;
  // Last beat retires the request
  assign ot_i.pop = r_hs && rlast_o;

  // Transaction flag and beat counter
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      active_q <= 1'b0;
      beat_q   <= '0;
    end else begin
      if (!active_q) begin
        // Start one cycle after a request reaches the head
        active_q <= ot_i.valid;
        beat_q   <= '0;
      end else if (ot_i.pop) begin
        active_q <= 1'b0;
        beat_q   <= '0;
      end else if (r_hs) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

endmodule

//--- hdl/axi_req_decode.sv
`include "noc_axi_params.svh"

module axi_req_decode
  import noc_axi_pkg::*;
#(
  parameter bit IS_READ = 1'b0
) (
  input  logic                   clk_axi,
  input  logic                   arst_axi,
  input  logic                   avalid_i,
  input  logic [`NOC_ADDR_W-1:0] aaddr_i,
  input  logic [`NOC_LEN_W-1:0]  alen_i,
  input  logic [2:0]             asize_i,
  input  logic [1:0]             aburst_i,
  input  logic [`NOC_ID_W-1:0]   aid_i,
  input  logic [`NOC_NUM_VC-1:0] rx_empty_i,
  output logic                   aready_o,
  axi_ot_if.decode               ot_o
);

  // Each side owns one window only
  localparam logic [`NOC_ADDR_W-1:0] BASE     = IS_READ ? `NOC_RD_BASE : `NOC_WR_BASE;
  localparam logic [`NOC_ADDR_W-1:0] STRIDE   = `NOC_ADDR_W'(`NOC_VC_STRIDE);
  localparam logic [`NOC_ADDR_W-1:0] WIN_SIZE = `NOC_ADDR_W'(`NOC_NUM_VC * `NOC_VC_STRIDE);
  localparam mm_region_e             REGION   = IS_READ ? REGION_RD_FIFO : REGION_WR_FIFO;

  logic [`NOC_ADDR_W-1:0] offset;
  logic [`NOC_ADDR_W-1:0] vc_idx;
  logic [`NOC_VC_W-1:0]   req_vc;
  logic                   in_win;
  logic                   buf_empty;
  logic                   req_err;
  logic                   push;
  logic                   q_full;
  logic                   q_empty;
  logic                   rdy_q;
  ot_entry_t              push_entry;
  ot_entry_t              head_entry;

  // ************************************************************
  // Request check
  // ************************************************************
  assign offset = aaddr_i - BASE;
  assign vc_idx = offset / STRIDE;
  assign req_vc = vc_idx[`NOC_VC_W-1:0];
  // Inside the window, on a slot boundary, below the channel count
  assign in_win = (aaddr_i >= BASE) && (offset < WIN_SIZE) && ((offset % STRIDE) == '0);

  // Reads must find a flit waiting in the channel
  assign buf_empty = IS_READ ? rx_empty_i[req_vc] : 1'b0;

  assign req_err = (aburst_i != BURST_INCR) || (asize_i != 3'd2) || !in_win || buf_empty;

  // Illegal requests are queued too, they finish with SLVERR
  assign push = avalid_i && aready_o;

  assign push_entry.addr   = aaddr_i;
  assign push_entry.len    = alen_i;
  assign push_entry.id     = aid_i;
  assign push_entry.vc     = req_vc;
  assign push_entry.region = REGION;
  assign push_entry.error  = req_err;

  // Ready comes up the cycle after reset is released
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      rdy_q <= 1'b0;
    end else begin
      rdy_q <= 1'b1;
    end
  end

  assign aready_o = rdy_q && !q_full;

  // Outstanding request queue
  sync_fifo #(
    .DEPTH (`NOC_OT_DEPTH),
    .WIDTH ($bits(ot_entry_t))
  ) u_ot_fifo (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .write_i  (push),
    .read_i   (ot_o.pop),
    .data_i   (push_entry),
    .data_o   (head_entry),
    .full_o   (q_full),
    .empty_o  (q_empty)
  );

  // ************************************************************
  // Head decode
  // ************************************************************
  always_comb begin
    ot_o.entry = head_entry;
    // Executors steer on region alone
    if (head_entry.error) begin
      ot_o.entry.region = REGION_NONE;
    end
  end

  assign ot_o.valid = !q_empty;

endmodule

//--- hdl/axi_wr_execute.sv
`include "noc_axi_params.svh"

module axi_wr_execute
  import noc_axi_pkg::*;
(
  input  logic                   clk_axi,
  input  logic                   arst_axi,
  input  logic                   wvalid_i,
  input  logic [`NOC_DATA_W-1:0] wdata_i,
  input  logic                   wlast_i,
  input  logic                   bready_i,
  input  logic                   pkt_ready_i,
  output logic                   wready_o,
  output logic                   bvalid_o,
  output axi_resp_e              bresp_o,
  output logic [`NOC_ID_W-1:0]   bid_o,
  output logic                   pkt_valid_o,
  output logic [`NOC_VC_W-1:0]   pkt_vc_o,
  output logic                   pkt_head_o,
  output logic                   pkt_last_o,
  output logic [`NOC_LEN_W-1:0]  pkt_len_o,
  output logic [`NOC_DATA_W-1:0] pkt_data_o,
  axi_ot_if.exec                 ot_i
);

  ot_entry_t head;
  logic      is_pkt;
  logic      w_hs;
  logic      head_q;

  assign head = ot_i.entry;

  // Legal burst into the write window, beats become flits
  assign is_pkt = ot_i.valid && (head.region == REGION_WR_FIFO);

  // Error bursts are drained without waiting on the NoC
  assign wready_o = ot_i.valid && !bvalid_o && (is_pkt ? pkt_ready_i : 1'b1);
  assign w_hs     = wvalid_i && wready_o;

  // ************************************************************
  // Packet output
  // ************************************************************
  assign pkt_valid_o = is_pkt && wvalid_i && wready_o;
  assign pkt_vc_o    = head.vc;
  assign pkt_head_o  = head_q;
  assign pkt_last_o  = wlast_i;
  assign pkt_len_o   = head.len;
  assign pkt_data_o  = wdata_i;

  // Set again after each last beat, so the next burst opens a packet
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      head_q <= 1'b1;
    end else if (w_hs) begin
      head_q <= wlast_i;
    end
  end

  // Burst done, drop the request
  assign ot_i.pop = w_hs && wlast_i;

  // ************************************************************
  // B channel
  // ************************************************************
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      bvalid_o <= 1'b0;
    end else if (ot_i.pop) begin
      bvalid_o <= 1'b1;
    end else if (bready_i) begin
      bvalid_o <= 1'b0;
    end
  end

  // Response payload captured with the last beat
  always_ff @(posedge clk_axi) begin
    if (ot_i.pop) begin
      bresp_o <= head.error ? RESP_SLVERR : RESP_OKAY;
      bid_o   <= head.id;
    end
  end

endmodule

//--- hdl/noc_axi_params.svh
`ifndef NOC_AXI_PARAMS_SVH
`define NOC_AXI_PARAMS_SVH

// ************************************************************
// Bus widths
// ************************************************************
`define NOC_DATA_W    32
`define NOC_ADDR_W    16
`define NOC_ID_W      4
`define NOC_LEN_W     8

// Virtual channels
`define NOC_NUM_VC    2
`define NOC_VC_W      1

// Queue depths
`define NOC_OT_DEPTH  4
`define NOC_RX_DEPTH  8

// ************************************************************
// Address map
// ************************************************************
`define NOC_WR_BASE   16'h1000
`define NOC_RD_BASE   16'h2000
// One word slot per channel, 8 bytes apart
`define NOC_VC_STRIDE 8

`endif

//--- hdl/noc_axi_pkg.sv
`include "noc_axi_params.svh"

package noc_axi_pkg;

  // Address space a request lands in
  // NONE also marks a rejected request
  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_WR_FIFO,
    REGION_RD_FIFO
  } mm_region_e;

  // AXI response codes in use
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } axi_resp_e;

  // AXI burst types
  typedef enum logic [1:0] {
    BURST_FIXED,
    BURST_INCR,
    BURST_WRAP
  } axi_burst_e;

  // One queued address request
  typedef struct packed {
    logic [`NOC_ADDR_W-1:0] addr;
    logic [`NOC_LEN_W-1:0]  len;
    logic [`NOC_ID_W-1:0]   id;
    logic [`NOC_VC_W-1:0]   vc;
    mm_region_e             region;
    logic                   error;
  } ot_entry_t;

endpackage

//--- hdl/noc_axi_slave.sv
`include "noc_axi_params.svh"

module noc_axi_slave (
  input  logic                   clk_axi,
  input  logic                   arst_axi,
  // Write address
  input  logic                   awvalid_i,
  input  logic [`NOC_ADDR_W-1:0] awaddr_i,
  input  logic [`NOC_LEN_W-1:0]  awlen_i,
  input  logic [2:0]             awsize_i,
  input  logic [1:0]             awburst_i,
  input  logic [`NOC_ID_W-1:0]   awid_i,
  output logic                   awready_o,
  // Write data
  input  logic                   wvalid_i,
  input  logic [`NOC_DATA_W-1:0] wdata_i,
  input  logic                   wlast_i,
  output logic                   wready_o,
  // Write response
  input  logic                   bready_i,
  output logic                   bvalid_o,
  output logic [1:0]             bresp_o,
  output logic [`NOC_ID_W-1:0]   bid_o,
  // Read address
  input  logic                   arvalid_i,
  input  logic [`NOC_ADDR_W-1:0] araddr_i,
  input  logic [`NOC_LEN_W-1:0]  arlen_i,
  input  logic [2:0]             arsize_i,
  input  logic [1:0]             arburst_i,
  input  logic [`NOC_ID_W-1:0]   arid_i,
  output logic                   arready_o,
  // Read data
  input  logic                   rready_i,
  output logic                   rvalid_o,
  output logic [`NOC_DATA_W-1:0] rdata_o,
  output logic [1:0]             rresp_o,
  output logic [`NOC_ID_W-1:0]   rid_o,
  output logic                   rlast_o,
  // Packet out toward the NoC
  input  logic                   pkt_ready_i,
  output logic                   pkt_valid_o,
  output logic [`NOC_VC_W-1:0]   pkt_vc_o,
  output logic                   pkt_head_o,
  output logic                   pkt_last_o,
  output logic [`NOC_LEN_W-1:0]  pkt_len_o,
  output logic [`NOC_DATA_W-1:0] pkt_data_o,
  // Flits in from the NoC
  input  logic                   rx_valid_i,
  input  logic [`NOC_VC_W-1:0]   rx_vc_i,
  input  logic [`NOC_DATA_W-1:0] rx_data_i,
  output logic                   rx_ready_o
);

  logic [`NOC_NUM_VC-1:0] rx_empty;
  logic [`NOC_VC_W-1:0]   rd_vc;
  logic [`NOC_DATA_W-1:0] rd_data;
  logic                   rd_pop;

  axi_ot_if wr_ot ();
  axi_ot_if rd_ot ();

  // ************************************************************
  // Write path
  // ************************************************************
  axi_req_decode #(.IS_READ(1'b0)) u_wr_decode (
    .clk_axi (clk_axi), .arst_axi (arst_axi), .avalid_i (awvalid_i), .aaddr_i (awaddr_i),
    .alen_i (awlen_i), .asize_i (awsize_i), .aburst_i (awburst_i), .aid_i (awid_i),
    .rx_empty_i ('0), .aready_o (awready_o), .ot_o (wr_ot)
  );

  axi_wr_execute u_wr_execute (
    .clk_axi (clk_axi), .arst_axi (arst_axi), .wvalid_i (wvalid_i), .wdata_i (wdata_i),
    .wlast_i (wlast_i), .bready_i (bready_i), .pkt_ready_i (pkt_ready_i),
    .wready_o (wready_o), .bvalid_o (bvalid_o), .bresp_o (bresp_o), .bid_o (bid_o),
    .pkt_valid_o (pkt_valid_o), .pkt_vc_o (pkt_vc_o), .pkt_head_o (pkt_head_o),
    .pkt_last_o (pkt_last_o), .pkt_len_o (pkt_len_o), .pkt_data_o (pkt_data_o),
    .ot_i (wr_ot)
  );

  // ************************************************************
  // Read path
  // ************************************************************
  axi_req_decode #(.IS_READ(1'b1)) u_rd_decode (
    .clk_axi (clk_axi), .arst_axi (arst_axi), .avalid_i (arvalid_i), .aaddr_i (araddr_i),
    .alen_i (arlen_i), .asize_i (arsize_i), .aburst_i (arburst_i), .aid_i (arid_i),
    .rx_empty_i (rx_empty), .aready_o (arready_o), .ot_o (rd_ot)
  );

  axi_rd_execute u_rd_execute (
    .clk_axi (clk_axi), .arst_axi (arst_axi), .rready_i (rready_i), .empty_i (rx_empty),
    .buf_data_i (rd_data), .rvalid_o (rvalid_o), .rdata_o (rdata_o), .rresp_o (rresp_o),
    .rid_o (rid_o), .rlast_o (rlast_o), .rd_vc_o (rd_vc), .rd_pop_o (rd_pop),
    .ot_i (rd_ot)
  );

  // Flits from the NoC, one queue per channel
  noc_rx_buffers u_rx_buffers (
    .clk_axi (clk_axi), .arst_axi (arst_axi), .rx_valid_i (rx_valid_i), .rx_vc_i (rx_vc_i),
    .rx_data_i (rx_data_i), .rd_vc_i (rd_vc), .rd_pop_i (rd_pop), .rx_ready_o (rx_ready_o),
    .empty_o (rx_empty), .rd_data_o (rd_data)
  );

endmodule

//--- hdl/noc_rx_buffers.sv
`include "noc_axi_params.svh"

module noc_rx_buffers (
  input  logic                   clk_axi,
  input  logic                   arst_axi,
  input  logic                   rx_valid_i,
  input  logic [`NOC_VC_W-1:0]   rx_vc_i,
  input  logic [`NOC_DATA_W-1:0] rx_data_i,
  input  logic [`NOC_VC_W-1:0]   rd_vc_i,
  input  logic                   rd_pop_i,
  output logic                   rx_ready_o,
  output logic [`NOC_NUM_VC-1:0] empty_o,
  output logic [`NOC_DATA_W-1:0] rd_data_o
);

  logic [`NOC_NUM_VC-1:0] full;
  logic [`NOC_NUM_VC-1:0] wr_en;
  logic [`NOC_NUM_VC-1:0] rd_en;
  logic [`NOC_DATA_W-1:0] head_data [`NOC_NUM_VC];

  // Flow control toward the NoC per addressed channel
  assign rx_ready_o = !full[rx_vc_i];

  // ************************************************************
  // One FIFO per virtual channel
  // ************************************************************
  for (genvar v = 0; v < `NOC_NUM_VC; v++) begin : gen_vc
    // Incoming flit steered by its channel tag
    assign wr_en[v] = rx_valid_i && (rx_vc_i == `NOC_VC_W'(v)) && !full[v];
    // Read side pops only the selected channel
    assign rd_en[v] = rd_pop_i && (rd_vc_i == `NOC_VC_W'(v));

    sync_fifo #(
      .DEPTH (`NOC_RX_DEPTH),
      .WIDTH (`NOC_DATA_W)
    ) u_vc_fifo (
      .clk_axi  (clk_axi),
      .arst_axi (arst_axi),
      .write_i  (wr_en[v]),
      .read_i   (rd_en[v]),
      .data_i   (rx_data_i),
      .data_o   (head_data[v]),
      .full_o   (full[v]),
      .empty_o  (empty_o[v])
    );
  end

  // Head of the selected channel
  assign rd_data_o = head_data[rd_vc_i];

endmodule

//--- hdl/sync_fifo.sv
module sync_fifo #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 32
) (
  input  logic             clk_axi,
  input  logic             arst_axi,
  input  logic             write_i,
  input  logic             read_i,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  // Overflow and underflow are simply ignored
  assign do_wr = write_i && !full_o;
  assign do_rd = read_i && !empty_o;

  assign full_o  = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);

  // Head word is always visible, read only advances it
  assign data_o = mem[rd_ptr];

  // Storage array
  always_ff @(posedge clk_axi) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Fill level only moves when exactly one side is active
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- sim/noc_axi_slave_props.sv
`include "noc_axi_params.svh"

module noc_axi_slave_props (
  input logic                   clk_axi,
  input logic                   arst_axi,
  input logic                   bvalid_o,
  input logic                   bready_i,
  input logic [1:0]             bresp_o,
  input logic [`NOC_ID_W-1:0]   bid_o,
  input logic                   rvalid_o,
  input logic                   rready_i,
  input logic [`NOC_DATA_W-1:0] rdata_o,
  input logic                   pkt_valid_o,
  input logic                   wready_o
);

  // ************************************************************
  // Reset
  // ************************************************************
  // No response may be offered while in reset
  a_rst_quiet: assert property (@(posedge clk_axi) arst_axi |-> !bvalid_o && !rvalid_o)
    else $error("B or R valid while in reset");

  // ************************************************************
  // AXI stability
  // ************************************************************
  // Stalled B response keeps its payload
  a_b_stable: assert property (@(posedge clk_axi) disable iff (arst_axi)
    bvalid_o && !bready_i |=> $stable(bresp_o) && $stable(bid_o))
    else $error("B payload changed while stalled");

  // Stalled R beat keeps its data
  a_r_stable: assert property (@(posedge clk_axi) disable iff (arst_axi)
    rvalid_o && !rready_i |=> $stable(rdata_o))
    else $error("R data changed while stalled");

  // A flit only leaves with an accepted W beat
  a_pkt_wready: assert property (@(posedge clk_axi) disable iff (arst_axi)
    pkt_valid_o |-> wready_o)
    else $error("Packet valid without W ready");

endmodule

bind noc_axi_slave noc_axi_slave_props u_props (
  .clk_axi     (clk_axi),
  .arst_axi    (arst_axi),
  .bvalid_o    (bvalid_o),
  .bready_i    (bready_i),
  .bresp_o     (bresp_o),
  .bid_o       (bid_o),
  .rvalid_o    (rvalid_o),
  .rready_i    (rready_i),
  .rdata_o     (rdata_o),
  .pkt_valid_o (pkt_valid_o),
  .wready_o    (wready_o)
);

//--- sim/tb_noc_axi_slave.sv
`include "noc_axi_params.svh"

module tb_noc_axi_slave
  import noc_axi_pkg::*;
();

  localparam int TMO = 2000;

  // DUT ports grouped by channel
  logic                   clk_axi, arst_axi;
  logic                   awvalid_i, awready_o, arvalid_i, arready_o;
  logic [`NOC_ADDR_W-1:0] awaddr_i, araddr_i;
  logic [`NOC_LEN_W-1:0]  awlen_i, arlen_i, pkt_len_o;
  logic [2:0]             awsize_i, arsize_i;
  logic [1:0]             awburst_i, arburst_i, bresp_o, rresp_o;
  logic [`NOC_ID_W-1:0]   awid_i, arid_i, bid_o, rid_o;
  logic                   wvalid_i, wlast_i, wready_o, bready_i, bvalid_o;
  logic                   rready_i, rvalid_o, rlast_o;
  logic [`NOC_DATA_W-1:0] wdata_i, rdata_o, pkt_data_o, rx_data_i;
  logic                   pkt_ready_i, pkt_valid_o, pkt_head_o, pkt_last_o;
  logic [`NOC_VC_W-1:0]   pkt_vc_o, rx_vc_i;
  logic                   rx_valid_i, rx_ready_o;

  // Expected traffic filled by stimulus and consumed by the checker
  logic [63:0] exp_pkt [$];
  logic [63:0] exp_b [$];
  logic [63:0] exp_r [$];
  // Flits the NoC has delivered and no read has claimed yet
  logic [`NOC_DATA_W-1:0] rx_model [`NOC_NUM_VC][$];

  string test_name;
  int    n_tests;
  int    n_checks;
  int    n_errors;
  int    test_err0;
  event  abort_ev;

  noc_axi_slave u_dut (.*);

  initial begin
    clk_axi = 1'b0;
    forever #5 clk_axi = ~clk_axi;
  end

  // Random back-pressure on packet out, B and R
  initial begin
    pkt_ready_i = 1'b0;
    bready_i    = 1'b0;
    rready_i    = 1'b0;
    forever begin
      @(negedge clk_axi);
      pkt_ready_i = ($urandom % 4) != 0;
      bready_i    = ($urandom % 2) != 0;
      rready_i    = ($urandom % 3) != 0;
    end
  end

  // Run ends here when a wait gives up
  initial begin
    @(abort_ev);
    $display("sim failed");
    $finish;
  end

  // ************************************************************
  // Reference model
  // ************************************************************
  // Response and channel from the address map, burst, size and buffer fill
  function automatic logic [1:0] ref_resp(input logic [`NOC_ADDR_W-1:0] addr,
                                          input logic [1:0] burst, input logic [2:0] size,
                                          input bit is_read, output int vc);
    int off;
    off = int'(addr) - (is_read ? int'(`NOC_RD_BASE) : int'(`NOC_WR_BASE));
    vc  = (off >= 0) ? off / `NOC_VC_STRIDE : 0;
    if (burst != BURST_INCR || size != 3'd2 || off < 0 || off % `NOC_VC_STRIDE != 0 ||
        vc >= `NOC_NUM_VC) begin
      vc = 0;
      return RESP_SLVERR;
    end
    // Read of a channel with nothing waiting
    if (is_read && rx_model[vc].size() == 0) begin
      return RESP_SLVERR;
    end
    return RESP_OKAY;
  endfunction

  task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic flag_error(input string msg);
    n_errors++;
    $display("%s in test %s", msg, test_name);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout waiting for %s in test %s", what, test_name);
    -> abort_ev;
    // Caller parks here while the run ends
    forever @(posedge clk_axi);
  endtask

  // ************************************************************
  // Bus drivers
  // ************************************************************
  function automatic logic ready_of(input string ch);
    if (ch == "aw") return awready_o;
    if (ch == "w") return wready_o;
    if (ch == "ar") return arready_o;
    return rx_ready_o;
  endfunction

  // Hold the beat until the handshake on a rising edge
  task automatic wait_ready(input string ch);
    int t;
    t = 0;
    do begin
      @(posedge clk_axi);
      t++;
    end while (!ready_of(ch) && t < TMO);
    if (!ready_of(ch)) abort_on_timeout({ch, " ready"});
  endtask

  task automatic write_burst(input logic [`NOC_ADDR_W-1:0] addr, input logic [7:0] len,
                             input logic [2:0] size, input logic [1:0] burst);
    logic [1:0]  resp;
    logic [3:0]  id;
    logic [31:0] data [$];
    int          vc;
    id   = 4'($urandom);
    resp = ref_resp(addr, burst, size, 1'b0, vc);
    for (int i = 0; i <= int'(len); i++) begin
      data.push_back($urandom);
      // Illegal bursts are swallowed and no flit leaves
      if (resp == RESP_OKAY) begin
        exp_pkt.push_back(64'({1'(vc), i == 0, i == int'(len), len, data[i]}));
      end
    end
    exp_b.push_back(64'({resp, id}));
    @(negedge clk_axi);
    awvalid_i = 1'b1;
    awaddr_i  = addr;
    awlen_i   = len;
    awsize_i  = size;
    awburst_i = burst;
    awid_i    = id;
    wait_ready("aw");
    @(negedge clk_axi);
    awvalid_i = 1'b0;
    foreach (data[i]) begin
      wvalid_i = 1'b1;
      wdata_i  = data[i];
      wlast_i  = (i == data.size() - 1);
      wait_ready("w");
      @(negedge clk_axi);
    end
    wvalid_i = 1'b0;
    wlast_i  = 1'b0;
  endtask

  task automatic read_burst(input logic [`NOC_ADDR_W-1:0] addr, input logic [7:0] len,
                            input logic [2:0] size, input logic [1:0] burst);
    logic [1:0] resp;
    logic [3:0] id;
    int         vc;
    id   = 4'($urandom);
    resp = ref_resp(addr, burst, size, 1'b1, vc);
    if (resp == RESP_OKAY) begin
      for (int i = 0; i <= int'(len); i++) begin
        exp_r.push_back(64'({rx_model[vc].pop_front(), resp, id, i == int'(len)}));
      end
    end else begin
      // One zero beat whatever the burst length
      exp_r.push_back(64'({32'h0, resp, id, 1'b1}));
    end
    @(negedge clk_axi);
    arvalid_i = 1'b1;
    araddr_i  = addr;
    arlen_i   = len;
    arsize_i  = size;
    arburst_i = burst;
    arid_i    = id;
    wait_ready("ar");
    @(negedge clk_axi);
    arvalid_i = 1'b0;
  endtask

  // Flits arriving from the NoC
  task automatic push_rx(input int vc, input int count);
    logic [31:0] d;
    for (int i = 0; i < count; i++) begin
      d = $urandom;
      @(negedge clk_axi);
      rx_valid_i = 1'b1;
      rx_vc_i    = 1'(vc);
      rx_data_i  = d;
      wait_ready("rx");
      rx_model[vc].push_back(d);
    end
    @(negedge clk_axi);
    rx_valid_i = 1'b0;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err0 = n_errors;
  endtask

  // Wait until every expected beat and response has been seen
  task automatic end_test();
    int t;
    t = 0;
    while ((exp_pkt.size() + exp_b.size() + exp_r.size()) != 0 && t < TMO) begin
      @(negedge clk_axi);
      t++;
    end
    if ((exp_pkt.size() + exp_b.size() + exp_r.size()) != 0) begin
      abort_on_timeout("responses");
    end else begin
      n_tests++;
      if (n_errors == test_err0) $display("Test %s: ok", test_name);
      else $display("Test %s: %0d errors", test_name, n_errors - test_err0);
    end
  endtask

  // ************************************************************
  // Checker
  // ************************************************************
  always @(posedge clk_axi) begin
    if (!arst_axi) begin
      if (pkt_valid_o && pkt_ready_i) begin
        if (exp_pkt.size() == 0) flag_error("Packet beat with none expected");
        else compare("packet beat", exp_pkt.pop_front(),
                     64'({pkt_vc_o, pkt_head_o, pkt_last_o, pkt_len_o, pkt_data_o}));
      end
      if (bvalid_o && bready_i) begin
        if (exp_b.size() == 0) flag_error("Write response with none expected");
        else compare("write response", exp_b.pop_front(), 64'({bresp_o, bid_o}));
      end
      if (rvalid_o && rready_i) begin
        if (exp_r.size() == 0) flag_error("Read beat with none expected");
        else compare("read beat", exp_r.pop_front(), 64'({rdata_o, rresp_o, rid_o, rlast_o}));
      end
    end
  end

  // ************************************************************
  // Test sequence
  // ************************************************************
  initial begin
    void'($urandom(32'h533c6db2));
    arst_axi = 1'b1;
    {awvalid_i, awaddr_i, awlen_i, awsize_i, awburst_i, awid_i, wvalid_i, wdata_i,
     wlast_i, arvalid_i, araddr_i, arlen_i, arsize_i, arburst_i, arid_i, rx_valid_i,
     rx_vc_i, rx_data_i} = '0;
    n_tests   = 0;
    n_checks  = 0;
    n_errors  = 0;

    begin_test("reset_state");
    repeat (16) @(negedge clk_axi);
    // Address channels stay closed while in reset
    compare("ready in reset", 64'(2'b00), 64'({awready_o, arready_o}));
    arst_axi = 1'b0;
    wait_ready("aw");
    // Idle outputs once AW ready is up
    compare("idle outputs", 64'(4'b0001), 64'({bvalid_o, rvalid_o, pkt_valid_o, arready_o}));
    end_test();

    begin_test("write_bursts");
    for (int i = 0; i < 4; i++) begin
      write_burst(16'(`NOC_WR_BASE + (i % 2) * `NOC_VC_STRIDE), 8'($urandom % 8), 3'd2,
                  BURST_INCR);
    end
    end_test();

    begin_test("illegal_writes");
    write_burst(16'(`NOC_WR_BASE), 8'd2, 3'd2, BURST_FIXED);
    write_burst(16'(`NOC_WR_BASE + `NOC_VC_STRIDE), 8'd1, 3'd1, BURST_INCR);
    write_burst(16'h3000, 8'd0, 3'd2, BURST_INCR);
    write_burst(16'(`NOC_WR_BASE + 4), 8'd1, 3'd2, BURST_INCR);
    write_burst(16'(`NOC_WR_BASE + 2 * `NOC_VC_STRIDE), 8'd0, 3'd2, BURST_INCR);
    end_test();

    // Both channels filled and then drained by bursts
    begin_test("read_bursts");
    push_rx(0, 6);
    push_rx(1, 6);
    read_burst(16'(`NOC_RD_BASE), 8'd3, 3'd2, BURST_INCR);
    read_burst(16'(`NOC_RD_BASE + `NOC_VC_STRIDE), 8'd5, 3'd2, BURST_INCR);
    read_burst(16'(`NOC_RD_BASE), 8'd1, 3'd2, BURST_INCR);
    end_test();

    // Empty channels first, then bad requests while channel 0 holds flits
    begin_test("illegal_reads");
    read_burst(16'(`NOC_RD_BASE), 8'd0, 3'd2, BURST_INCR);
    read_burst(16'(`NOC_RD_BASE + `NOC_VC_STRIDE), 8'd3, 3'd2, BURST_INCR);
    push_rx(0, 2);
    read_burst(16'(`NOC_RD_BASE + 4), 8'd2, 3'd2, BURST_INCR);
    read_burst(16'(`NOC_RD_BASE + 2 * `NOC_VC_STRIDE), 8'd1, 3'd2, BURST_INCR);
    read_burst(16'(`NOC_RD_BASE), 8'd3, 3'd2, BURST_WRAP);
    read_burst(16'(`NOC_RD_BASE), 8'd0, 3'd1, BURST_INCR);
    end_test();

    begin_test("concurrent");
    push_rx(1, 3);
    fork
      write_burst(16'(`NOC_WR_BASE), 8'($urandom % 8), 3'd2, BURST_INCR);
      read_burst(16'(`NOC_RD_BASE + `NOC_VC_STRIDE), 8'd2, 3'd2, BURST_INCR);
    join
    end_test();

    $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
